/* rtl/rvIsaPkg.sv */
package rvIsaPkg;

    localparam int xlen = 32;               // RV32I register width

    typedef logic [xlen-1:0] wordT;         // data word
    typedef logic [xlen-1:0] addrT;         // byte address
    typedef logic [31:0]     instrT;        // raw instruction word
    typedef logic [4:0]      regIdxT;       // x0..x31
    typedef logic [6:0]      opcodeT;       // instr[6:0]
    typedef logic [2:0]      funct3T;       // instr[14:12]

    //////////////////////////////
    // major opcodes
    localparam opcodeT opLoad   = 7'b0000011;   // lw
    localparam opcodeT opStore  = 7'b0100011;   // sw
    localparam opcodeT opOp     = 7'b0110011;   // R-type alu
    localparam opcodeT opOpImm  = 7'b0010011;   // I-type alu
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opLui    = 7'b0110111;

    //////////////////////////////
    // funct3 of the alu group, shared by R and I forms
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Srl    = 3'b101;   // srl or sra, split by bit 30
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // branch conditions
    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;
    localparam funct3T f3Blt  = 3'b100;
    localparam funct3T f3Bge  = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

    localparam addrT pcStep = 32'd4;        // one word per instruction

endpackage

/* rtl/coreCtrlPkg.sv */
package coreCtrlPkg;

    // alu operation, picked by the decoder
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra
    } aluOpE;

    // immediate layout of the instruction
    typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immKindE;

    // register write-back source
    typedef enum logic [1:0] {resAlu, resMem, resLink} resSrcE;

    // alu operand A source
    typedef enum logic [1:0] {srcReg, srcPc, srcZero} srcAE;

    //////////////////////////////
    // decoder to datapath control word
    typedef struct packed {
        logic             regWrite;   // write rd at end of cycle
        logic             memWrite;   // sw
        logic             branch;     // conditional, taken per funct3
        logic             jump;       // jal, jalr
        logic             jalrSel;    // target base is rs1, not pc
        srcAE             srcA;
        logic             srcBImm;    // operand B is the immediate
        aluOpE            aluOp;
        resSrcE           resSrc;
        rvIsaPkg::funct3T funct3;     // branch condition select
    } ctrlT;

    // everything off, for unknown opcodes
    localparam ctrlT ctrlIdle = '{
        regWrite: 1'b0, memWrite: 1'b0, branch: 1'b0, jump: 1'b0, jalrSel: 1'b0,
        srcA: srcReg, srcBImm: 1'b0, aluOp: aluAdd, resSrc: resAlu, funct3: 3'b000
    };

endpackage

/* rtl/ctrlDecoder.sv */
module ctrlDecoder
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  instrT instr,
    output ctrlT  ctrl,
    output wordT  immExt
);

    opcodeT  opcode;
    funct3T  funct3;
    logic    funct7b5;      // instr[30]
    logic    isSub;
    aluOpE   aluFunc;       // op for R/I alu group
    immKindE immKind;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign isSub    = funct7b5 & opcode[5];   // addi has no sub form

    //////////////////////////////
    // alu decoder
    always_comb begin
        case (funct3)
            f3AddSub: aluFunc = isSub ? aluSub : aluAdd;
            f3Sll:    aluFunc = aluSll;
            f3Slt:    aluFunc = aluSlt;
            f3Sltu:   aluFunc = aluSltu;
            f3Xor:    aluFunc = aluXor;
            f3Srl:    aluFunc = funct7b5 ? aluSra : aluSrl;   // srai also uses bit 30
            f3Or:     aluFunc = aluOr;
            f3And:    aluFunc = aluAnd;
        endcase
    end

    //////////////////////////////
    // main decoder
    always_comb begin
        ctrl        = ctrlIdle;
        ctrl.funct3 = funct3;
        immKind     = immI;
        case (opcode)
            opLoad: begin               // rs1 + imm, data from memory
                ctrl.regWrite = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.resSrc   = resMem;
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.srcBImm  = 1'b1;
                immKind       = immS;
            end
            opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFunc;
            end
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.aluOp    = aluFunc;
            end
            opBranch: begin             // compare via subtract flags
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
                immKind     = immB;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.resSrc   = resLink;
                immKind       = immJ;
            end
            opJalr: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.jalrSel  = 1'b1;
                ctrl.resSrc   = resLink;
            end
            opAuipc: begin              // pc + upper imm
                ctrl.regWrite = 1'b1;
                ctrl.srcA     = srcPc;
                ctrl.srcBImm  = 1'b1;
                immKind       = immU;
            end
            opLui: begin                // 0 + upper imm
                ctrl.regWrite = 1'b1;
                ctrl.srcA     = srcZero;
                ctrl.srcBImm  = 1'b1;
                immKind       = immU;
            end
            default: ctrl = ctrlIdle;  // unknown, no side effects
        endcase
    end

    //////////////////////////////
    // immediate extender, sign from instr[31]
    always_comb begin
        case (immKind)
            immI:    immExt = {{20{instr[31]}}, instr[31:20]};
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ:    immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            immU:    immExt = {instr[31:12], 12'b0};
            default: immExt = '0;
        endcase
    end

endmodule

/* rtl/regFile.sv */
module regFile
    import rvIsaPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  regIdxT rdAddrA,
    input  regIdxT rdAddrB,
    output wordT   rdDataA,
    output wordT   rdDataB,
    input  logic   wrEn,
    input  regIdxT wrAddr,
    input  wordT   wrData
);

    wordT regs [1:31];      // x0 has no storage

    // write at the edge that ends the instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin   // writes to x0 dropped
            regs[wrAddr] <= wrData;
        end
    end

    // combinational reads, x0 hardwired to zero
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

/* rtl/aluExec.sv */
module aluExec
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  ctrlT ctrl,
    input  wordT rs1Val,
    input  wordT rs2Val,
    input  addrT pc,
    input  wordT immExt,
    output wordT aluResult,
    output logic redirect,
    output addrT target
);

    wordT       opA;
    wordT       opB;
    wordT       opBInv;     // opB or ~opB for subtract
    wordT       sum;
    logic       cout;
    logic       isSub;
    logic       isAddSub;
    logic       ovf;        // raw adder overflow
    logic       v;
    logic       c;
    logic       n;
    logic       z;
    logic       cond;
    logic [4:0] shamt;
    addrT       jumpBase;
    addrT       rawTarget;

    //////////////////////////////
    // operand select
    always_comb begin
        case (ctrl.srcA)
            srcPc:   opA = pc;          // auipc
            srcZero: opA = '0;          // lui
            default: opA = rs1Val;
        endcase
    end
    assign opB   = ctrl.srcBImm ? immExt : rs2Val;
    assign shamt = opB[4:0];

    //////////////////////////////
    // adder, shared by add, sub, slt, sltu and branches
    assign isSub    = (ctrl.aluOp == aluSub) || (ctrl.aluOp == aluSlt) ||
                      (ctrl.aluOp == aluSltu);
    assign isAddSub = isSub || (ctrl.aluOp == aluAdd);
    assign opBInv   = isSub ? ~opB : opB;
    assign {cout, sum} = {1'b0, opA} + {1'b0, opBInv} + {{xlen{1'b0}}, isSub};
    assign ovf = ~(isSub ^ opA[xlen-1] ^ opB[xlen-1]) & (opA[xlen-1] ^ sum[xlen-1]);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = sum;
            aluSub:  aluResult = sum;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, sum[xlen-1] ^ ovf};   // signed less
            aluSltu: aluResult = {{(xlen-1){1'b0}}, ~cout};              // borrow out
            aluSll:  aluResult = opA << shamt;
            aluSrl:  aluResult = opA >> shamt;
            aluSra:  aluResult = wordT'($signed(opA) >>> shamt);
            default: aluResult = sum;
        endcase
    end

    // flags, v and c only meaningful on add/sub
    assign v = ovf & isAddSub;
    assign c = cout & isAddSub;
    assign n = aluResult[xlen-1];
    assign z = (aluResult == '0);

    //////////////////////////////
    // branch condition from subtract flags
    always_comb begin
        case (ctrl.funct3)
            f3Beq:   cond = z;
            f3Bne:   cond = ~z;
            f3Blt:   cond = n ^ v;
            f3Bge:   cond = ~(n ^ v);
            f3Bltu:  cond = ~c;        // no carry means a < b unsigned
            f3Bgeu:  cond = c;
            default: cond = 1'b0;
        endcase
    end

    assign redirect = (ctrl.branch & cond) | ctrl.jump;

    // target adder, jalr clears bit 0
    assign jumpBase  = ctrl.jalrSel ? rs1Val : pc;
    assign rawTarget = jumpBase + immExt;
    assign target    = {rawTarget[xlen-1:1], rawTarget[0] & ~ctrl.jalrSel};

endmodule

/* rtl/rvCore.sv */
module rvCore
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output addrT  imemAddr,
    input  instrT imemData,
    output addrT  dmemAddr,
    output wordT  dmemWrData,
    output logic  dmemWe,
    input  wordT  dmemRdData
);

    addrT   pc;
    addrT   pcNext;
    addrT   pcPlus4;        // also the link value
    ctrlT   ctrl;
    wordT   immExt;
    regIdxT rs1Idx;
    regIdxT rs2Idx;
    regIdxT rdIdx;
    wordT   rs1Val;
    wordT   rs2Val;
    wordT   aluResult;
    logic   redirect;
    addrT   target;
    wordT   result;         // write-back value

    //////////////////////////////
    // program counter
    assign pcPlus4 = pc + pcStep;
    assign pcNext  = redirect ? target : pcPlus4;   // taken branch or jump

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign imemAddr = pc;

    // register fields straight from the fetched word
    assign rs1Idx = imemData[19:15];
    assign rs2Idx = imemData[24:20];
    assign rdIdx  = imemData[11:7];

    //////////////////////////////
    // decode, register read, execute
    ctrlDecoder i_ctrlDecoder (
        .instr  (imemData),
        .ctrl   (ctrl),
        .immExt (immExt)
    );

    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rs1Idx),
        .rdAddrB (rs2Idx),
        .rdDataA (rs1Val),
        .rdDataB (rs2Val),
        .wrEn    (ctrl.regWrite),
        .wrAddr  (rdIdx),
        .wrData  (result)
    );

    aluExec i_aluExec (
        .ctrl      (ctrl),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val),
        .pc        (pc),
        .immExt    (immExt),
        .aluResult (aluResult),
        .redirect  (redirect),
        .target    (target)
    );

    //////////////////////////////
    // result select
    always_comb begin
        case (ctrl.resSrc)
            resAlu:  result = aluResult;
            resMem:  result = dmemRdData;   // lw, same-cycle read
            resLink: result = pcPlus4;      // jal, jalr
            default: result = aluResult;
        endcase
    end

    // data memory port, word access only
    assign dmemAddr   = aluResult;
    assign dmemWrData = rs2Val;
    assign dmemWe     = ctrl.memWrite;

endmodule

/* verif/rvCore_asserts.sv */
module rvCoreAsserts
    import rvIsaPkg::*;
(
    input logic clk,
    input logic rst,
    input addrT imemAddr,
    input addrT dmemAddr,
    input logic dmemWe
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////
    // fetch on word boundaries only, jalr clears bit 0 but not bit 1
    imemAligned: assert property (@(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00)
        else $error("imemAddr 0x%08h is not word aligned", imemAddr);

    // sw is the only store, so always a full word
    dmemAligned: assert property (@(posedge clk) disable iff (rst)
        dmemWe |-> (dmemAddr[1:0] == 2'b00))
        else $error("store to dmemAddr 0x%08h is not word aligned", dmemAddr);

    dmemWeKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(dmemWe))
        else $error("dmemWe is unknown outside reset");

endmodule

bind rvCore rvCoreAsserts i_rvCoreAsserts (.*);

/* verif/coreTb.sv */
module coreTb
    import rvIsaPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int imemWords   = 64;
    localparam int dmemWords   = 256;
    localparam int resetCycles = 8;
    localparam int idleCycles  = 4;     // pc parked this long means the final self-loop

    typedef struct packed {
        addrT addr;
        wordT data;
    } storeT;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    addrT  imemAddr;
    instrT imemData;
    addrT  dmemAddr;
    wordT  dmemWrData;
    logic  dmemWe;
    wordT  dmemRdData;

    instrT imem [imemWords];
    wordT  dmem [dmemWords];
    storeT expQ [$];                    // expected stores with the oldest first
    int    instrCount = 0;
    logic  loaded = 1'b0;

    always #4 clk = ~clk;               // 8 ns period

    rvCore i_rvCore (
        .clk        (clk),
        .rst        (rst),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .dmemAddr   (dmemAddr),
        .dmemWrData (dmemWrData),
        .dmemWe     (dmemWe),
        .dmemRdData (dmemRdData)
    );

    //////////////////////////////
    // memory models with combinational read
    assign imemData   = imem[imemAddr[7:2]];
    assign dmemRdData = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWrData;  // captured at end of the sw cycle
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // I lines fill imem from 0, S lines queue stores, # starts a comment
    task automatic loadStimulus();
        int               fd;
        int               code;
        byte              tag;
        logic [8*128-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      d;
        storeT            s;
        fd = $fopen("verif/core_stimulus.txt", "r");
        if (fd == 0) begin
            failRun("could not open verif/core_stimulus.txt");
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);        // drop rest of line
            end else if (tag == "I") begin
                code = $fscanf(fd, " %h", d);
                if (code != 1) begin
                    failRun("stimulus file holds an I entry without an instruction word");
                end
                if (instrCount >= imemWords) begin
                    failRun("program in the stimulus file does not fit the instruction memory");
                end
                imem[instrCount] = d;
                instrCount++;
            end else if (tag == "S") begin
                code = $fscanf(fd, " %h %h", a, d);
                if (code != 2) begin
                    failRun("stimulus file holds an S entry without both address and data");
                end
                s.addr = a;
                s.data = d;
                expQ.push_back(s);
            end else begin
                failRun("stimulus file holds an entry that is neither I, S nor a comment");
            end
        end
        $fclose(fd);
    endtask

    task automatic verifyResetState(input string phase);
        assert (dmemWe === 1'b0) else begin
            failRun($sformatf("CHECK FAILED dmemWe %s: got 0x%0h, expected 0x0", phase, dmemWe));
        end
        assert (imemAddr === '0) else begin
            failRun($sformatf("CHECK FAILED imemAddr %s: got 0x%08h, expected 0x00000000",
                              phase, imemAddr));
        end
    endtask

    task automatic compareStore();
        storeT exp;
        if (expQ.size() == 0) begin
            failRun($sformatf("store to 0x%08h seen after every expected store", dmemAddr));
        end
        exp = expQ.pop_front();
        assert (dmemAddr === exp.addr) else begin
            failRun($sformatf("CHECK FAILED dmemAddr: got 0x%08h, expected 0x%08h",
                              dmemAddr, exp.addr));
        end
        assert (dmemWrData === exp.data) else begin
            failRun($sformatf("CHECK FAILED dmemWrData at 0x%08h: got 0x%08h, expected 0x%08h",
                              exp.addr, dmemWrData, exp.data));
        end
    endtask

    // one instruction per cycle so mid-cycle sees each store once
    always @(negedge clk) begin
        if (!rst && dmemWe) begin
            compareStore();
        end
    end

    //////////////////////////////
    // main sequence
    initial begin
        addrT lastPc;
        int   sameCnt;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = '0;               // opcode 0 decodes to no-op control
        end
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = '0;
        end
        loadStimulus();
        loaded = 1'b1;
        repeat (resetCycles) begin
            @(negedge clk);
            verifyResetState("during reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        verifyResetState("on the first cycle after reset");
        lastPc  = imemAddr;
        sameCnt = 0;
        while (sameCnt < idleCycles) begin
            @(negedge clk);
            if (imemAddr == lastPc) begin
                sameCnt++;
            end else begin
                sameCnt = 0;
                lastPc  = imemAddr;
            end
        end
        if (expQ.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            failRun($sformatf("program parked with %0d expected stores never seen", expQ.size()));
        end
    end

    // watchdog scaled to the program length
    initial begin
        int limit;
        wait (loaded);
        limit = instrCount * 4 + 100;
        repeat (limit) @(posedge clk);
        failRun($sformatf("timeout: program did not park in its final loop within %0d cycles",
                          limit));
    end

endmodule

/* src.f */
rtl/rvIsaPkg.sv
rtl/coreCtrlPkg.sv
rtl/ctrlDecoder.sv
rtl/regFile.sv
rtl/aluExec.sv
rtl/rvCore.sv
verif/rvCore_asserts.sv
verif/coreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "make clean  remove $(OBJDIR) and $(LOG)"
	@echo "variables   VERILATOR TOP FILELIST OBJDIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP) -f $(FILELIST)
	-./$(OBJDIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/core_stimulus.txt */
# I <instruction word hex>, loaded from address 0 upward
# S <store address hex> <store data hex>, expected stores in order
I 800000b7  # 00 lui x1, 0x80000
I fff00113  # 04 addi x2, x0, -1
I 402081b3  # 08 sub x3, x1, x2
I 10302023  # 0c sw x3, 0x100(x0)
S 00000100 80000001
I 4040d213  # 10 srai x4, x1, 4
I 10402223  # 14 sw x4, 0x104(x0)
S 00000104 f8000000
I 0000a2b3  # 18 slt x5, x1, x0
I 10502423  # 1c sw x5, 0x108(x0)
S 00000108 00000001
I 00103333  # 20 sltu x6, x0, x1
I 10602623  # 24 sw x6, 0x10c(x0)
S 0000010c 00000001
I 0041c3b3  # 28 xor x7, x3, x4
I 10702823  # 2c sw x7, 0x110(x0)
S 00000110 78000001
I 12345417  # 30 auipc x8, 0x12345
I 10802a23  # 34 sw x8, 0x114(x0)
S 00000114 12345030
I 00500013  # 38 addi x0, x0, 5
I 10002c23  # 3c sw x0, 0x118(x0)
S 00000118 00000000
I 00108463  # 40 beq x1, x1, +8 taken
I 1e202823  # 44 sw x2, 0x1f0(x0) skipped
I 00109463  # 48 bne x1, x1, +8 not taken
I 10102e23  # 4c sw x1, 0x11c(x0)
S 0000011c 80000000
I 00114463  # 50 blt x2, x1, +8 not taken
I 12202023  # 54 sw x2, 0x120(x0)
S 00000120 ffffffff
I 00115463  # 58 bge x2, x1, +8 taken
I 1e202823  # 5c sw x2, 0x1f0(x0) skipped
I 00116463  # 60 bltu x2, x1, +8 not taken
I 12302223  # 64 sw x3, 0x124(x0)
S 00000124 80000001
I 00117463  # 68 bgeu x2, x1, +8 taken
I 1e202823  # 6c sw x2, 0x1f0(x0) skipped
I 0080056f  # 70 jal x10, +8
I 1e202823  # 74 sw x2, 0x1f0(x0) skipped
I 12a02423  # 78 sw x10, 0x128(x0)
S 00000128 00000074
I 00000617  # 7c auipc x12, 0
I 00d605e7  # 80 jalr x11, 13(x12), lands on 0x88
I 1e202823  # 84 sw x2, 0x1f0(x0) skipped
I 12b02623  # 88 sw x11, 0x12c(x0)
S 0000012c 00000084
I 10402683  # 8c lw x13, 0x104(x0)
I 12d02823  # 90 sw x13, 0x130(x0)
S 00000130 f8000000
I 0000006f  # 94 jal x0, 0 parks here
